// ==== include/pdp1d_params.svh ====
// pdp1d sizing constants
`ifndef PDP1D_PARAMS_SVH
`define PDP1D_PARAMS_SVH

// lanes carried per input beat
`define PDP1D_LANES 4
// 8-bit element plus 3 guard bits for sums
`define PDP1D_LANE_W 11
// channel groups with their own running result
`define PDP1D_GROUPS 8
`define PDP1D_GRP_W 3
// window size field, elements minus one
`define PDP1D_SIZE_W 3
// stages standing in for the adder latency
`define PDP1D_PIPE_DEPTH 4
// apb decode
`define PDP1D_APB_AW 8
`define PDP1D_ADDR_CTRL 8'h00

`endif

// ==== src/pdp1d_pkg.sv ====
// pdp1d shared types
`include "pdp1d_params.svh"

package pdp1d_pkg;

  // pooling operation, code 3 is rejected by the register block
  typedef enum logic [1:0] {
    POOL_MEAN = 2'd0,
    POOL_MAX  = 2'd1,
    POOL_MIN  = 2'd2
  } pool_type_e;

  // one signed lane
  typedef logic signed [`PDP1D_LANE_W-1:0] lane_t;

  // full beat, lane 0 in the low bits
  typedef lane_t [`PDP1D_LANES-1:0] beat_data_t;

  // channel group index
  typedef logic [`PDP1D_GRP_W-1:0] grp_t;

  // window elements minus one
  typedef logic [`PDP1D_SIZE_W-1:0] win_size_t;

endpackage

// ==== src/pdp1d_apb_regs.sv ====
// pdp1d control registers
`timescale 1ns/100ps
`include "pdp1d_params.svh"

module pdp1d_apb_regs (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`PDP1D_APB_AW-1:0]  paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      pool_en,
  output pdp1d_pkg::pool_type_e     pool_type
);

  ////////////////////////////////////////////////////////////
  // access decode
  ////////////////////////////////////////////////////////////

  logic access;
  logic addr_hit;
  logic type_bad;
  logic wr_ok;

  // access phase only, setup phase does nothing
  assign access   = psel & penable;
  assign addr_hit = (paddr == `PDP1D_ADDR_CTRL);
  // type code 3 has no operator behind it
  assign type_bad = pwrite & (pwdata[2:1] == 2'd3);
  assign wr_ok    = access & pwrite & addr_hit & ~type_bad;

  // no wait states
  assign pready  = 1'b1;
  // bad address or bad type, write is dropped
  assign pslverr = access & (~addr_hit | type_bad);

  ////////////////////////////////////////////////////////////
  // ctrl register
  ////////////////////////////////////////////////////////////

  // bit 0 enable, bits 2:1 pooling type
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pool_en   <= 1'b0;
      pool_type <= pdp1d_pkg::POOL_MEAN;
    end else if (wr_ok) begin
      pool_en   <= pwdata[0];
      pool_type <= pdp1d_pkg::pool_type_e'(pwdata[2:1]);
    end
  end

  ////////////////////////////////////////////////////////////
  // read back
  ////////////////////////////////////////////////////////////

  // unused bits read as zero
  always_comb begin
    prdata = 32'd0;
    if (psel && !pwrite && addr_hit) begin
      prdata[0]   = pool_en;
      prdata[2:1] = pool_type;
    end
  end

endmodule

// ==== src/pdp1d_pipe.sv ====
// pdp1d latency pipeline
`timescale 1ns/100ps
`include "pdp1d_params.svh"

module pdp1d_pipe (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   in_valid,
  input  pdp1d_pkg::beat_data_t  in_data,
  input  pdp1d_pkg::grp_t        in_grp,
  input  logic                   in_first,
  input  logic                   in_last,
  input  logic                   pipe_ready,
  output logic                   in_ready,
  output logic                   pipe_valid,
  output pdp1d_pkg::beat_data_t  pipe_data,
  output pdp1d_pkg::grp_t        pipe_grp,
  output logic                   pipe_first,
  output logic                   pipe_last
);

  localparam int DEPTH = `PDP1D_PIPE_DEPTH;

  // per stage state, index 0 nearest the input
  logic                  stg_vld   [DEPTH];
  logic                  stg_rdy   [DEPTH];
  pdp1d_pkg::beat_data_t stg_data  [DEPTH];
  pdp1d_pkg::grp_t       stg_grp   [DEPTH];
  logic                  stg_first [DEPTH];
  logic                  stg_last  [DEPTH];

  // what feeds each stage, and who drains it
  logic                  src_vld   [DEPTH];
  pdp1d_pkg::beat_data_t src_data  [DEPTH];
  pdp1d_pkg::grp_t       src_grp   [DEPTH];
  logic                  src_first [DEPTH];
  logic                  src_last  [DEPTH];
  logic                  dn_rdy    [DEPTH];

  genvar k;
  generate
    for (k = 0; k < DEPTH; k++) begin : g_stg
      if (k == 0) begin : g_head
        assign src_vld[k]   = in_valid;
        assign src_data[k]  = in_data;
        assign src_grp[k]   = in_grp;
        assign src_first[k] = in_first;
        assign src_last[k]  = in_last;
      end else begin : g_body
        assign src_vld[k]   = stg_vld[k-1];
        assign src_data[k]  = stg_data[k-1];
        assign src_grp[k]   = stg_grp[k-1];
        assign src_first[k] = stg_first[k-1];
        assign src_last[k]  = stg_last[k-1];
      end

      // last stage drains into the accumulator
      if (k == DEPTH - 1) begin : g_tail
        assign dn_rdy[k] = pipe_ready;
      end else begin : g_mid
        assign dn_rdy[k] = stg_rdy[k+1];
      end

      // load when empty or when the next stage takes our beat
      assign stg_rdy[k] = ~stg_vld[k] | dn_rdy[k];

      always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
        if (!nvdla_core_rstn) begin
          stg_vld[k] <= 1'b0;
        end else if (stg_rdy[k]) begin
          stg_vld[k] <= src_vld[k];
        end
      end

      // payload follows the handshake
      always_ff @(posedge nvdla_core_clk) begin
        if (src_vld[k] && stg_rdy[k]) begin
          stg_data[k]  <= src_data[k];
          stg_grp[k]   <= src_grp[k];
          stg_first[k] <= src_first[k];
          stg_last[k]  <= src_last[k];
        end
      end
    end
  endgenerate

  assign in_ready   = stg_rdy[0];
  assign pipe_valid = stg_vld[DEPTH-1];
  assign pipe_data  = stg_data[DEPTH-1];
  assign pipe_grp   = stg_grp[DEPTH-1];
  assign pipe_first = stg_first[DEPTH-1];
  assign pipe_last  = stg_last[DEPTH-1];

endmodule

// ==== src/pdp1d_accum.sv ====
// pdp1d per-group accumulator
`timescale 1ns/100ps
`include "pdp1d_params.svh"

module pdp1d_accum (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  pdp1d_pkg::pool_type_e  pool_type,
  input  logic                   pipe_valid,
  input  pdp1d_pkg::beat_data_t  pipe_data,
  input  pdp1d_pkg::grp_t        pipe_grp,
  input  logic                   pipe_first,
  input  logic                   pipe_last,
  input  logic                   out_ready,
  output logic                   pipe_ready,
  output logic                   out_valid,
  output pdp1d_pkg::beat_data_t  out_data,
  output pdp1d_pkg::win_size_t   out_size
);

  localparam int GROUPS = `PDP1D_GROUPS;
  localparam int LANES  = `PDP1D_LANES;

  ////////////////////////////////////////////////////////////
  // lane operator
  ////////////////////////////////////////////////////////////

  // acc is the running value, din the new element
  function automatic pdp1d_pkg::lane_t pool_lane(
    input pdp1d_pkg::lane_t      acc,
    input pdp1d_pkg::lane_t      din,
    input pdp1d_pkg::pool_type_e op
  );
    pdp1d_pkg::lane_t res;
    begin
      case (op)
        // sum wraps at lane width, divide happens downstream
        pdp1d_pkg::POOL_MEAN: res = pdp1d_pkg::lane_t'(acc + din);
        pdp1d_pkg::POOL_MAX:  res = (din > acc) ? din : acc;
        pdp1d_pkg::POOL_MIN:  res = (din < acc) ? din : acc;
        default:              res = '0;
      endcase
      pool_lane = res;
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // group buffers
  ////////////////////////////////////////////////////////////

  pdp1d_pkg::beat_data_t res_buf  [GROUPS];
  pdp1d_pkg::win_size_t  size_buf [GROUPS];

  pdp1d_pkg::beat_data_t cur_res;
  pdp1d_pkg::win_size_t  cur_size;
  pdp1d_pkg::beat_data_t comb_res;
  pdp1d_pkg::beat_data_t new_res;
  pdp1d_pkg::win_size_t  new_size;
  logic                  consume;

  // exit beat taken when the output slot is free or draining
  assign pipe_ready = ~out_valid | out_ready;
  assign consume    = pipe_valid & pipe_ready;

  // running state of the addressed group
  assign cur_res  = res_buf[pipe_grp];
  assign cur_size = size_buf[pipe_grp];

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      comb_res[l] = pool_lane(cur_res[l], pipe_data[l], pool_type);
    end
  end

  // first beat restarts the window
  assign new_res  = pipe_first ? pipe_data : comb_res;
  assign new_size = pipe_first ? '0 : pdp1d_pkg::win_size_t'(cur_size + 1'b1);

  // only the addressed group moves
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      for (int g = 0; g < GROUPS; g++) begin
        res_buf[g]  <= '0;
        size_buf[g] <= '0;
      end
    end else if (consume) begin
      res_buf[pipe_grp]  <= new_res;
      size_buf[pipe_grp] <= new_size;
    end
  end

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  // held while out_ready is low
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
    end else if (consume && pipe_last) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // result of the window that just closed
  always_ff @(posedge nvdla_core_clk) begin
    if (consume && pipe_last) begin
      out_data <= new_res;
      out_size <= new_size;
    end
  end

endmodule

// ==== src/pdp1d_top.sv ====
// pdp1d pooling unit top
`timescale 1ns/100ps
`include "pdp1d_params.svh"

module pdp1d_top (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  // apb config port
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`PDP1D_APB_AW-1:0]  paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  // input beats
  input  logic                      in_valid,
  input  pdp1d_pkg::beat_data_t     in_data,
  input  pdp1d_pkg::grp_t           in_grp,
  input  logic                      in_first,
  input  logic                      in_last,
  output logic                      in_ready,
  // pooled results
  output logic                      out_valid,
  output pdp1d_pkg::beat_data_t     out_data,
  output pdp1d_pkg::win_size_t      out_size,
  input  logic                      out_ready
);

  logic                  pool_en;
  pdp1d_pkg::pool_type_e pool_type;
  logic                  pipe_in_ready;
  logic                  pipe_valid;
  pdp1d_pkg::beat_data_t pipe_data;
  pdp1d_pkg::grp_t       pipe_grp;
  logic                  pipe_first;
  logic                  pipe_last;
  logic                  pipe_ready;

  pdp1d_apb_regs u_regs (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .pool_en        (pool_en),
    .pool_type      (pool_type)
  );

  // disabled unit takes no beats
  assign in_ready = pipe_in_ready & pool_en;

  pdp1d_pipe u_pipe (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .in_valid       (in_valid & pool_en),
    .in_data        (in_data),
    .in_grp         (in_grp),
    .in_first       (in_first),
    .in_last        (in_last),
    .pipe_ready     (pipe_ready),
    .in_ready       (pipe_in_ready),
    .pipe_valid     (pipe_valid),
    .pipe_data      (pipe_data),
    .pipe_grp       (pipe_grp),
    .pipe_first     (pipe_first),
    .pipe_last      (pipe_last)
  );

  pdp1d_accum u_accum (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .pool_type      (pool_type),
    .pipe_valid     (pipe_valid),
    .pipe_data      (pipe_data),
    .pipe_grp       (pipe_grp),
    .pipe_first     (pipe_first),
    .pipe_last      (pipe_last),
    .out_ready      (out_ready),
    .pipe_ready     (pipe_ready),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_size       (out_size)
  );

endmodule

// ==== tests/tb_pdp1d.sv ====
// pdp1d pooling unit testbench
`timescale 1ns/100ps
`include "pdp1d_params.svh"

module tb_pdp1d;

  localparam int MAX_ROWS = 128;
  localparam logic [16:0] LFSR_SEED = 17'd76580;
  localparam logic [`PDP1D_APB_AW-1:0] ADDR_BAD = 8'h04;

  logic                         nvdla_core_clk;
  logic                         nvdla_core_rstn;
  logic                         psel;
  logic                         penable;
  logic                         pwrite;
  logic [`PDP1D_APB_AW-1:0]     paddr;
  logic [31:0]                  pwdata;
  logic [31:0]                  prdata;
  logic                         pready;
  logic                         pslverr;
  logic                         in_valid;
  pdp1d_pkg::beat_data_t        in_data;
  pdp1d_pkg::grp_t              in_grp;
  logic                         in_first;
  logic                         in_last;
  logic                         in_ready;
  logic                         out_valid;
  pdp1d_pkg::beat_data_t        out_data;
  pdp1d_pkg::win_size_t         out_size;
  logic                         out_ready;

  // stimulus table, one row per beat
  pdp1d_pkg::pool_type_e row_type  [MAX_ROWS];
  pdp1d_pkg::grp_t       row_grp   [MAX_ROWS];
  logic                  row_first [MAX_ROWS];
  logic                  row_last  [MAX_ROWS];
  pdp1d_pkg::beat_data_t row_data  [MAX_ROWS];
  int                    n_rows = 0;

  // window length per group, group 0 in the low nibble
  pdp1d_pkg::pool_type_e phase_type [3] = '{pdp1d_pkg::POOL_MAX, pdp1d_pkg::POOL_MIN,
                                            pdp1d_pkg::POOL_MEAN};
  logic [31:0]           phase_lens [3] = '{32'h8765_4321, 32'h1234_5678, 32'h7564_8132};

  // reference model state
  pdp1d_pkg::beat_data_t exp_res  [`PDP1D_GROUPS];
  pdp1d_pkg::win_size_t  exp_size [`PDP1D_GROUPS];
  pdp1d_pkg::beat_data_t exp_data_q [$];
  pdp1d_pkg::win_size_t  exp_size_q [$];

  logic [16:0] lfsr = LFSR_SEED;
  string       test_name = "reset";
  int          data_errs = 0;
  int          size_errs = 0;
  int          apb_errs = 0;
  int          other_errs = 0;
  int          n_out = 0;

  pdp1d_top DUT (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #50 nvdla_core_clk = ~nvdla_core_clk;
  end

  ////////////////////////////////////////////////////////////
  // random bits and the reference model
  ////////////////////////////////////////////////////////////

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    lfsr_next = {s[15:0], s[16] ^ s[13]};
  endfunction

  // one lfsr step per bit, newest bit lowest
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  // beats of all windows of a phase interleaved across groups
  task automatic build_rows();
    int len;
    pdp1d_pkg::lane_t v;
    for (int p = 0; p < 3; p++) begin
      for (int b = 0; b < 8; b++) begin
        for (int g = 0; g < `PDP1D_GROUPS; g++) begin
          len = int'(phase_lens[p][g*4 +: 4]);
          if (b < len) begin
            row_type[n_rows]  = phase_type[p];
            row_grp[n_rows]   = pdp1d_pkg::grp_t'(g);
            row_first[n_rows] = (b == 0);
            row_last[n_rows]  = (b == len - 1);
            for (int l = 0; l < `PDP1D_LANES; l++) begin
              v = pdp1d_pkg::lane_t'(take_bits(`PDP1D_LANE_W));
              // sum of two of these wraps past +1023
              if (phase_type[p] == pdp1d_pkg::POOL_MEAN && g == 0)
                v = 11'sd1000;
              row_data[n_rows][l] = v;
            end
            n_rows++;
          end
        end
      end
    end
  endtask

  // applied once per accepted beat
  task automatic model_row(input int r);
    pdp1d_pkg::grp_t g;
    int a;
    int d;
    int s;
    g = row_grp[r];
    if (row_first[r]) begin
      exp_res[g]  = row_data[r];
      exp_size[g] = '0;
    end else begin
      for (int l = 0; l < `PDP1D_LANES; l++) begin
        a = int'($signed(exp_res[g][l]));
        d = int'($signed(row_data[r][l]));
        case (row_type[r])
          pdp1d_pkg::POOL_MAX: s = (d > a) ? d : a;
          pdp1d_pkg::POOL_MIN: s = (d < a) ? d : a;
          default:             s = a + d;
        endcase
        // keep the low 11 bits, so sums wrap
        exp_res[g][l] = pdp1d_pkg::lane_t'(s);
      end
      exp_size[g] = pdp1d_pkg::win_size_t'(exp_size[g] + 3'd1);
    end
    if (row_last[r]) begin
      exp_data_q.push_back(exp_res[g]);
      exp_size_q.push_back(exp_size[g]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input pdp1d_pkg::beat_data_t exp,
                            input pdp1d_pkg::beat_data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("MISMATCH %s data expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_size(input string name, input pdp1d_pkg::win_size_t exp,
                            input pdp1d_pkg::win_size_t act);
    if (act !== exp) begin
      size_errs++;
      $display("MISMATCH %s size expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_apb(input string name, input logic [31:0] exp_rd, input logic exp_err,
                           input logic [31:0] act_rd, input logic act_err);
    if (act_rd !== exp_rd || act_err !== exp_err) begin
      apb_errs++;
      $display("MISMATCH %s prdata/pslverr expected %h/%b actual %h/%b",
               name, exp_rd, exp_err, act_rd, act_err);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus and flow helpers
  ////////////////////////////////////////////////////////////

  // starts and ends on a rising edge, sampled mid access phase
  task automatic apb_access(input logic wr, input logic [`PDP1D_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output logic rdy);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge nvdla_core_clk);
    penable <= 1'b1;
    @(negedge nvdla_core_clk);
    rdata = prdata;
    err   = pslverr;
    rdy   = pready;
    @(posedge nvdla_core_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic check_reg(input string name, input logic wr,
                           input logic [`PDP1D_APB_AW-1:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp_rd, input logic exp_err);
    logic [31:0] rd;
    logic err;
    logic rdy;
    apb_access(wr, addr, wdata, rd, err, rdy);
    check_apb(name, exp_rd, exp_err, rd, err);
    // no wait states on this bus
    if (rdy !== 1'b1) begin
      other_errs++;
      $display("pready was not high in the access phase of %s", name);
    end
  endtask

  // wait for every queued result, bounded
  task automatic drain(input int max_cycles);
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < max_cycles) begin
      @(posedge nvdla_core_clk);
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      other_errs++;
      $display("%0d expected results of %s never came out", exp_data_q.size(), test_name);
      exp_data_q.delete();
      exp_size_q.delete();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////

  // random back-pressure
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn)
      out_ready <= (take_bits(1) != 16'd0);
  end

  // handshake happens on the next rising edge
  always @(negedge nvdla_core_clk) begin
    string tag;
    if (nvdla_core_rstn && out_valid && out_ready) begin
      tag = $sformatf("%s result %0d", test_name, n_out);
      if (exp_data_q.size() == 0) begin
        other_errs++;
        $display("unexpected output in %s with data %h size %0d", test_name, out_data, out_size);
      end else begin
        check_data(tag, exp_data_q.pop_front(), out_data);
        check_size(tag, exp_size_q.pop_front(), out_size);
      end
      n_out++;
    end
  end

  initial begin
    @(posedge nvdla_core_rstn);
    repeat (n_rows * (`PDP1D_PIPE_DEPTH + 1) * 4 + 200) @(posedge nvdla_core_clk);
    $display("timeout in %s with %0d results outstanding", test_name, exp_data_q.size());
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    nvdla_core_rstn <= 1'b0;
    psel      <= 1'b0;
    penable   <= 1'b0;
    pwrite    <= 1'b0;
    paddr     <= '0;
    pwdata    <= '0;
    in_valid  <= 1'b0;
    in_data   <= '0;
    in_grp    <= '0;
    in_first  <= 1'b0;
    in_last   <= 1'b0;
    out_ready <= 1'b0;
    build_rows();
    repeat (10) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    @(posedge nvdla_core_clk);

    // register access
    check_reg("ctrl after reset", 1'b0, `PDP1D_ADDR_CTRL, 32'h0, 32'h0, 1'b0);
    check_reg("ctrl write", 1'b1, `PDP1D_ADDR_CTRL, 32'h3, 32'h0, 1'b0);
    check_reg("ctrl read", 1'b0, `PDP1D_ADDR_CTRL, 32'h0, 32'h3, 1'b0);
    check_reg("bad address write", 1'b1, ADDR_BAD, 32'h5, 32'h0, 1'b1);
    check_reg("ctrl after bad address", 1'b0, `PDP1D_ADDR_CTRL, 32'h0, 32'h3, 1'b0);
    check_reg("bad type write", 1'b1, `PDP1D_ADDR_CTRL, 32'h7, 32'h0, 1'b1);
    check_reg("ctrl after bad type", 1'b0, `PDP1D_ADDR_CTRL, 32'h0, 32'h3, 1'b0);

    // disabled unit must not take a beat
    test_name = "disabled";
    check_reg("disable write", 1'b1, `PDP1D_ADDR_CTRL, 32'h0, 32'h0, 1'b0);
    in_valid <= 1'b1;
    in_data  <= row_data[0];
    in_first <= 1'b1;
    in_last  <= 1'b1;
    repeat (6) begin
      @(negedge nvdla_core_clk);
      if (in_ready) begin
        other_errs++;
        $display("in_ready went high while the unit was disabled");
      end
    end
    @(posedge nvdla_core_clk);
    in_valid <= 1'b0;
    repeat (8) @(posedge nvdla_core_clk);

    // table rows, type change only with nothing in flight
    for (int r = 0; r < n_rows; r++) begin
      if (r == 0 || row_type[r] != row_type[r-1]) begin
        in_valid <= 1'b0;
        drain(400);
        test_name = $sformatf("%s pooling", row_type[r].name());
        check_reg("ctrl mode write", 1'b1, `PDP1D_ADDR_CTRL, {29'd0, row_type[r], 1'b1},
                  32'h0, 1'b0);
      end
      in_valid <= 1'b1;
      in_data  <= row_data[r];
      in_grp   <= row_grp[r];
      in_first <= row_first[r];
      in_last  <= row_last[r];
      @(negedge nvdla_core_clk);
      while (!in_ready) @(negedge nvdla_core_clk);
      @(posedge nvdla_core_clk);
      model_row(r);
    end
    in_valid <= 1'b0;
    drain(400);
    repeat (4) @(posedge nvdla_core_clk);

    $display("errors data %0d size %0d apb %0d other %0d with %0d results seen",
             data_errs, size_errs, apb_errs, other_errs, n_out);
    if (data_errs + size_errs + apb_errs + other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
src/pdp1d_pkg.sv
src/pdp1d_apb_regs.sv
src/pdp1d_pipe.sv
src/pdp1d_accum.sv
src/pdp1d_top.sv
tests/tb_pdp1d.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pdp1d regression with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_pdp1d -f filelist.f -o tb_pdp1d > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_pdp1d > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
